// ==== uart_periph.f ====
verilog/uart_pkg.sv
verilog/uart_baud_timer.sv
verilog/uart_rx_fsm.sv
verilog/uart_tx_shifter.sv
verilog/uart_regs.sv
verilog/uart_periph.sv
dv/uart_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the uart_periph testbench with Verilator, run it, and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module uart_periph_tb -f uart_periph.f \
   && ./obj_dir/Vuart_periph_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "=== PASS ===" sim.log 2>/dev/null \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

// ==== dv/uart_periph_tb.sv ====
`timescale 1ns/1ps

module uart_periph_tb
   import uart_pkg::*;
();

   localparam int DIV_W      = 16;
   localparam int CLK_PERIOD = 100;
   localparam int RST_CYCLES = 16;
   localparam int BIT_DIV    = 8;    // divider used for both serial directions
   localparam int N_BYTES    = 8;
   // reset plus 8 frames each way at 10 x 8 cycles and the bus reads with a wide margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic          clk;
   logic          rst_int;
   uart_bus_req_t bus;
   logic [31:0]   rdata;
   logic          rdy;
   logic          txd;
   logic          rxd;
   logic          cts;
   logic          rts;
   logic          sel_q;   // bus select one cycle late
   int            cycle_cnt = 0;

   uart_periph #(
      .DIV_W (DIV_W)
   ) DUT (
      .clk     (clk),
      .rst_int (rst_int),
      .bus     (bus),
      .rdata   (rdata),
      .rdy     (rdy),
      .txd     (txd),
      .rxd     (rxd),
      .cts     (cts),
      .rts     (rts)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // failure handling and watchdog
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         abort_run();
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < TIMEOUT_CYCLES) else begin
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   always @(posedge clk) begin
      sel_q <= bus.sel;
   end

   // rdy is the select one cycle late
   assert property (@(posedge clk) disable iff (rst_int) rdy == sel_q)
      else begin
         $display("Mismatch rdy: got 0x%0h expected 0x%0h", $sampled(rdy), $sampled(sel_q));
         abort_run();
      end

   //////////////////////////////////////////////////////////////////////
   // bus and serial tasks entered on a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic bus_write(input uart_addr_e addr, input logic [31:0] wdata);
      bus.sel   = 1'b1;
      bus.write = 1'b1;
      bus.read  = 1'b0;
      bus.addr  = addr;
      bus.wdata = wdata;
      @(negedge clk);
      bus.sel   = 1'b0;
      bus.write = 1'b0;
   endtask

   task automatic bus_read(input uart_addr_e addr, output logic [31:0] val);
      bus.sel   = 1'b1;
      bus.read  = 1'b1;
      bus.write = 1'b0;
      bus.addr  = addr;
      #(CLK_PERIOD/4);   // mid low phase well before the next rising edge
      val = rdata;
      @(negedge clk);
      bus.sel  = 1'b0;
      bus.read = 1'b0;
   endtask

   task automatic read_expect(input uart_addr_e addr, input string name,
                              input logic [31:0] exp);
      logic [31:0] val;
      bus_read(addr, val);
      check_value(name, val, exp);
   endtask

   // 8N1 frame on rxd lsb first
   task automatic serial_send(input logic [7:0] b, input int bit_cycles);
      rxd = 1'b0;
      repeat (bit_cycles) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         rxd = b[i];
         repeat (bit_cycles) @(negedge clk);
      end
      rxd = 1'b1;   // stop
      repeat (bit_cycles) @(negedge clk);
   endtask

   // entered half a clock after the start bit begins
   task automatic serial_capture(input logic [7:0] b, input int bit_cycles);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      repeat (bit_cycles/2 - 1) @(negedge clk);   // move to the bit centre
      for (int i = 0; i < 10; i++) begin
         check_value("txd", 32'(txd), 32'(frame[i]));
         repeat (bit_cycles) @(negedge clk);
      end
   endtask

   task automatic wait_rx_valid(input int max_polls);
      logic [31:0] val;
      int          polls;
      polls = 0;
      val   = '0;
      while (val[0] !== 1'b1 && polls < max_polls) begin
         bus_read(read_valid, val);
         polls++;
      end
      assert (val[0] === 1'b1) else begin
         $display("receive buffer did not become valid within %0d reads", max_polls);
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] div_val;
      logic [7:0]  b;
      void'($urandom(17344));
      rst_int = 1'b1;
      bus     = '0;
      rxd     = 1'b1;   // line idle
      cts     = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst_int = 1'b0;
      @(negedge clk);

      // reset values
      check_value("txd", 32'(txd), 32'h1);
      check_value("rts", 32'(rts), 32'h0);
      read_expect(div, "div", 32'h1);
      read_expect(write_wait, "write_wait", 32'h0);
      read_expect(read_valid, "read_valid", 32'h0);
      read_expect(uart_addr_e'(3'd6), "rdata at address 6", 32'hFFFF_FFFF);

      div_val = {16'd0, 16'($urandom())};
      bus_write(div, div_val);
      read_expect(div, "div", div_val);
      bus_write(div, 32'(BIT_DIV));

      // transmit with busy checked while the frame goes out
      for (int n = 0; n < N_BYTES; n++) begin
         b = 8'($urandom());
         bus_write(data, {24'd0, b});
         fork
            serial_capture(b, BIT_DIV);
            begin
               read_expect(write_wait, "write_wait", 32'h1);
               repeat (UART_FRAME_W * BIT_DIV - 3) @(negedge clk);   // last cycle of the frame
               read_expect(write_wait, "write_wait", 32'h1);
            end
         join
         read_expect(write_wait, "write_wait", 32'h0);
      end

      // cts through the two-stage synchronizer
      cts = 1'b0;
      read_expect(write_wait, "write_wait", 32'h0);
      @(negedge clk);
      read_expect(write_wait, "write_wait", 32'h1);
      read_expect(write_wait, "write_wait", 32'h1);
      cts = 1'b1;
      repeat (2) @(negedge clk);
      read_expect(write_wait, "write_wait", 32'h0);

      // receive with rts flow control
      bus_write(rx_en, 32'h1);
      check_value("rts", 32'(rts), 32'h1);
      for (int n = 0; n < N_BYTES; n++) begin
         b = 8'($urandom());
         serial_send(b, BIT_DIV);
         wait_rx_valid(4 * BIT_DIV);
         check_value("rts", 32'(rts), 32'h0);   // buffer full
         read_expect(data, "data", {24'd0, b});
         read_expect(read_valid, "read_valid", 32'h0);
         check_value("rts", 32'(rts), 32'h1);
      end

      bus_write(rx_en, 32'h0);
      check_value("rts", 32'(rts), 32'h0);
      read_expect(read_valid, "read_valid", 32'h0);
      repeat (4) @(negedge clk);
      check_value("rts", 32'(rts), 32'h0);

      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== verilog/uart_periph.sv ====
`timescale 1ns/1ps

module uart_periph
   import uart_pkg::*;
#(
   parameter int DIV_W = 16
) (
   input  logic          clk,
   input  logic          rst_int,
   input  uart_bus_req_t bus,
   output logic [31:0]   rdata,
   output logic          rdy,
   output logic          txd,
   input  logic          rxd,
   input  logic          cts,
   output logic          rts
);

   logic [DIV_W-1:0] divider;

   // transmit path
   logic       tx_load;
   logic [7:0] tx_byte;
   logic       tx_busy;
   logic       tx_tick;
   logic       tx_timer_en;
   logic       tx_restart;

   // receive path
   logic       rx_done;
   logic [7:0] rx_byte;
   logic       rx_tick;
   logic       rx_timer_en;
   logic       rx_restart;
   logic       rx_half;

   //////////////////////////////////////////////////////////////////////
   // register block
   //////////////////////////////////////////////////////////////////////

   uart_regs #(
      .DIV_W (DIV_W)
   ) u_regs (
      .clk     (clk),
      .rst_int (rst_int),
      .bus     (bus),
      .rdata   (rdata),
      .rdy     (rdy),
      .divider (divider),
      .tx_load (tx_load),
      .tx_byte (tx_byte),
      .tx_busy (tx_busy),
      .rx_done (rx_done),
      .rx_byte (rx_byte),
      .cts     (cts),
      .rts     (rts)
   );

   //////////////////////////////////////////////////////////////////////
   // serial transmit
   //////////////////////////////////////////////////////////////////////

   uart_baud_timer #(
      .DIV_W (DIV_W)
   ) tx_timer (
      .clk     (clk),
      .rst_int (rst_int),
      .en      (tx_timer_en),
      .restart (tx_restart),
      .half    (1'b0),          // tx always runs full bit periods
      .divider (divider),
      .tick    (tx_tick)
   );

   uart_tx_shifter u_tx (
      .clk      (clk),
      .rst_int  (rst_int),
      .load     (tx_load),
      .byte_in  (tx_byte),
      .tick     (tx_tick),
      .timer_en (tx_timer_en),
      .restart  (tx_restart),
      .busy     (tx_busy),
      .txd      (txd)
   );

   //////////////////////////////////////////////////////////////////////
   // serial receive
   //////////////////////////////////////////////////////////////////////

   uart_baud_timer #(
      .DIV_W (DIV_W)
   ) rx_timer (
      .clk     (clk),
      .rst_int (rst_int),
      .en      (rx_timer_en),
      .restart (rx_restart),
      .half    (rx_half),
      .divider (divider),
      .tick    (rx_tick)
   );

   uart_rx_fsm u_rx (
      .clk      (clk),
      .rst_int  (rst_int),
      .rxd      (rxd),
      .tick     (rx_tick),
      .timer_en (rx_timer_en),
      .restart  (rx_restart),
      .half     (rx_half),
      .rx_done  (rx_done),
      .rx_byte  (rx_byte)
   );

endmodule

// ==== verilog/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs
   import uart_pkg::*;
#(
   parameter int DIV_W = 16
) (
   input  logic             clk,
   input  logic             rst_int,
   input  uart_bus_req_t    bus,
   output logic [31:0]      rdata,
   output logic             rdy,
   output logic [DIV_W-1:0] divider,
   output logic             tx_load,
   output logic [7:0]       tx_byte,
   input  logic             tx_busy,
   input  logic             rx_done,
   input  logic [7:0]       rx_byte,
   input  logic             cts,
   output logic             rts
);

   logic         wr_en;
   logic         rd_en;
   logic         div_we;
   logic         rx_en_we;
   logic         rx_pop;
   logic         rx_valid_q;
   logic         rx_en_q;
   logic [7:0]   rx_buf;
   logic [1:0]   cts_sync;
   uart_status_t status;

   assign wr_en = bus.sel & bus.write;
   assign rd_en = bus.sel & bus.read;

   //////////////////////////////////////////////////////////////////////
   // write decode
   //////////////////////////////////////////////////////////////////////

   assign div_we   = wr_en & (bus.addr == div);
   assign rx_en_we = wr_en & (bus.addr == rx_en);
   assign tx_load  = wr_en & (bus.addr == data);
   assign tx_byte  = bus.wdata[7:0];
   assign rx_pop   = rd_en & (bus.addr == data);   // data read empties buffer

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         divider    <= DIV_W'(1);
         rx_en_q    <= 1'b0;
         rx_valid_q <= 1'b0;
         cts_sync   <= 2'b00;
         rdy        <= 1'b0;
      end else begin
         if (div_we)   divider <= bus.wdata[DIV_W-1:0];
         if (rx_en_we) rx_en_q <= bus.wdata[0];
         // a byte landing in the same cycle as a pop wins
         if (rx_done)     rx_valid_q <= 1'b1;
         else if (rx_pop) rx_valid_q <= 1'b0;
         cts_sync <= {cts_sync[0], cts};
         rdy      <= bus.sel;
      end
   end

   // new byte overwrites even when valid is still set
   always_ff @(posedge clk) begin
      if (rx_done) rx_buf <= rx_byte;
   end

   assign status = '{tx_busy: tx_busy, rx_valid: rx_valid_q, rx_en_q: rx_en_q};

   assign rts = status.rx_en_q & ~status.rx_valid;   // ask for data only when empty

   //////////////////////////////////////////////////////////////////////
   // read mux
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      rdata = UART_RD_UNUSED;
      if (rd_en) begin
         case (bus.addr)
            write_wait: rdata = {31'd0, status.tx_busy | ~cts_sync[1]};
            div:        rdata = 32'(divider);
            data:       rdata = {24'd0, rx_buf};
            read_valid: rdata = {31'd0, status.rx_valid};
            default:    rdata = UART_RD_UNUSED;   // rx_en and holes
         endcase
      end
   end

endmodule

// ==== verilog/uart_tx_shifter.sv ====
`timescale 1ns/1ps

module uart_tx_shifter
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       rst_int,
   input  logic       load,
   input  logic [7:0] byte_in,
   input  logic       tick,
   output logic       timer_en,
   output logic       restart,
   output logic       busy,
   output logic       txd
);

   logic [UART_FRAME_W-1:0] frame;
   logic [3:0]              bit_cnt;   // bits left in the frame

   assign busy     = (bit_cnt != 4'd0);
   assign timer_en = busy;
   assign restart  = load;             // first bit gets a full period

   //////////////////////////////////////////////////////////////////////
   // frame shift register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         frame   <= '1;                // line idles high
         bit_cnt <= 4'd0;
      end else if (load) begin
         // stop, data, start from msb down
         frame   <= {1'b1, byte_in, 1'b0};
         bit_cnt <= 4'(UART_FRAME_W);
      end else if (busy && tick) begin
         frame   <= {1'b1, frame[UART_FRAME_W-1:1]};   // refill with idle level
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   assign txd = frame[0];

endmodule

// ==== verilog/uart_rx_fsm.sv ====
`timescale 1ns/1ps

module uart_rx_fsm (
   input  logic       clk,
   input  logic       rst_int,
   input  logic       rxd,
   input  logic       tick,
   output logic       timer_en,
   output logic       restart,
   output logic       half,
   output logic       rx_done,
   output logic [7:0] rx_byte
);

   typedef enum logic [1:0] {
      idle,
      start_centre,
      data_bits,
      stop
   } rx_state_e;

   rx_state_e  state;
   logic [2:0] bit_idx;
   logic [7:0] shift_q;

   //////////////////////////////////////////////////////////////////////
   // timer control
   //////////////////////////////////////////////////////////////////////

   assign restart  = (state == idle);           // keep count parked at 1
   assign timer_en = (state != idle);
   assign half     = (state == start_centre);   // only half a bit to the centre

   //////////////////////////////////////////////////////////////////////
   // state machine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state   <= idle;
         bit_idx <= '0;
      end else begin
         case (state)
            idle: begin
               if (!rxd) state <= start_centre;   // falling edge of start bit
            end
            start_centre: begin
               if (tick) begin
                  state   <= data_bits;
                  bit_idx <= '0;
               end
            end
            data_bits: begin
               if (tick) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= stop;
               end
            end
            stop: begin
               // stop level is not checked
               if (tick) state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (state == data_bits && tick) begin
         shift_q <= {rxd, shift_q[7:1]};
      end
   end

   assign rx_done = (state == stop) & tick;
   assign rx_byte = shift_q;

endmodule

// ==== verilog/uart_baud_timer.sv ====
`timescale 1ns/1ps

module uart_baud_timer #(
   parameter int DIV_W = 16
) (
   input  logic             clk,
   input  logic             rst_int,
   input  logic             en,
   input  logic             restart,
   input  logic             half,
   input  logic [DIV_W-1:0] divider,
   output logic             tick
);

   logic [DIV_W-1:0] cnt;
   logic [DIV_W:0]   cnt_cmp;   // one extra bit for the doubled count

   // half mode compares 2*cnt against the divider
   assign cnt_cmp = half ? {cnt, 1'b0} : {1'b0, cnt};

   assign tick = en & (cnt_cmp >= {1'b0, divider});

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cnt <= '0;
      end else if (restart) begin
         cnt <= DIV_W'(1);          // resync wins over enable
      end else if (!en) begin
         cnt <= '0;
      end else if (tick) begin
         cnt <= DIV_W'(1);          // period done
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      write_wait = 3'd0,   // tx busy or cts low (read only)
      div        = 3'd1,   // baud divider (read/write)
      data       = 3'd2,   // write sends and read pops the rx buffer
      read_valid = 3'd3,   // rx buffer valid (read only)
      rx_en      = 3'd4    // receive enable (write only)
   } uart_addr_e;

   // start + 8 data + stop
   localparam int UART_FRAME_W = 10;

   // value seen on reads of unused or write-only addresses
   localparam logic [31:0] UART_RD_UNUSED = 32'hFFFF_FFFF;

   //////////////////////////////////////////////////////////////////////
   // bus and status bundles
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        sel;
      logic        read;
      logic        write;
      uart_addr_e  addr;
      logic [31:0] wdata;
   } uart_bus_req_t;

   typedef struct packed {
      logic tx_busy;    // frame in flight
      logic rx_valid;   // byte waiting in buffer
      logic rx_en_q;    // receive enable flag
   } uart_status_t;

endpackage
